// File: src/frame_rd_pkg.sv
package frame_rd_pkg;

  //********************
  // axi4 read bus widths
  localparam int DATA_W  = 128;
  localparam int ADDR_W  = 16;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  //********************
  // axi4 codes
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

  // single fixed read id, no reordering
  localparam logic [ID_W-1:0] RD_ID = 4'd1;

  // full-width beats only
  localparam int BYTES_PER_WORD = DATA_W / 8;
  localparam logic [SIZE_W-1:0] SIZE_CODE = SIZE_W'($clog2(BYTES_PER_WORD));

  //********************
  // default frame geometry
  localparam int DEF_FRAME_BEATS = 64;
  localparam int DEF_BURST_LEN   = 8;
  localparam int DEF_BASE_ADDR   = 0;

  // sample fifo must hold at least two bursts
  localparam int DEF_FIFO_DEPTH  = 32;

  // memory model
  localparam int DEF_MEM_WORDS   = 256;
  localparam int DEF_RD_LATENCY  = 2;

endpackage

// File: src/axi_frame_rd_master.sv
module axi_frame_rd_master #(
  parameter int FRAME_BEATS = 64,
  parameter int BURST_LEN   = 8,
  parameter int BASE_ADDR   = 0
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_start,
  input  logic                               i_fifo_afull,
  // ar channel
  output logic                               o_arvalid,
  input  logic                               i_arready,
  output logic [frame_rd_pkg::ADDR_W-1:0]    o_araddr,
  output logic [frame_rd_pkg::LEN_W-1:0]     o_arlen,
  output logic [frame_rd_pkg::SIZE_W-1:0]    o_arsize,
  output logic [frame_rd_pkg::BURST_W-1:0]   o_arburst,
  output logic [frame_rd_pkg::ID_W-1:0]      o_arid,
  // r channel
  input  logic                               i_rvalid,
  output logic                               o_rready,
  input  logic [frame_rd_pkg::DATA_W-1:0]    i_rdata,
  input  logic                               i_rlast,
  input  logic [frame_rd_pkg::RESP_W-1:0]    i_rresp,
  input  logic [frame_rd_pkg::ID_W-1:0]      i_rid,
  // toward sample fifo
  output logic                               o_wr_en,
  output logic [frame_rd_pkg::DATA_W-1:0]    o_wr_data,
  output logic                               o_wr_last
);
  import frame_rd_pkg::*;

  localparam int CNT_W = $clog2(FRAME_BEATS + 1);
  localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_LEN * BYTES_PER_WORD);

  logic              start_meta;
  logic              start_sync;
  logic              start_prev;
  logic              start_rise;
  logic              run;
  logic              busy;
  logic              issue;
  logic              ar_hs;
  logic              rd_hs;
  logic              beat_ok;
  logic              frame_end;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  beat_cnt;

  //********************
  // start sync and edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_meta <= 1'b0;
      start_sync <= 1'b0;
      start_prev <= 1'b0;
    end else begin
      start_meta <= i_start;
      start_sync <= start_meta;
      start_prev <= start_sync;
    end
  end

  assign start_rise = start_sync & ~start_prev;

  // edges seen mid-frame are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else if (start_rise && !run) begin
      run <= 1'b1;
    end else if (frame_end) begin
      run <= 1'b0;
    end
  end

  //********************
  // ar channel
  assign ar_hs = o_arvalid & i_arready;

  // wait for the last beat of the previous burst to land in the fifo,
  // so the afull level seen here is final
  assign issue = run & ~busy & ~o_wr_en & ~i_fifo_afull;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_arvalid <= 1'b0;
      busy      <= 1'b0;
    end else if (issue) begin
      o_arvalid <= 1'b1;
      busy      <= 1'b1;
    end else begin
      if (ar_hs) begin
        o_arvalid <= 1'b0;
      end
      if (rd_hs && i_rlast) begin
        busy <= 1'b0;
      end
    end
  end

  // next burst address, bumped once the request is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= ADDR_W'(BASE_ADDR);
    end else if (start_rise && !run) begin
      addr_q <= ADDR_W'(BASE_ADDR);
    end else if (ar_hs) begin
      addr_q <= addr_q + BURST_BYTES;
    end
  end

  assign o_araddr  = addr_q;
  assign o_arlen   = LEN_W'(BURST_LEN - 1);
  assign o_arsize  = SIZE_CODE;
  assign o_arburst = BURST_INCR;
  assign o_arid    = RD_ID;

  //********************
  // r channel
  assign o_rready  = run;
  assign rd_hs     = i_rvalid & o_rready;
  // foreign id or error beats are not forwarded
  assign beat_ok   = rd_hs & (i_rid == RD_ID) & (i_rresp == RESP_OKAY);
  assign frame_end = beat_ok & (beat_cnt == CNT_W'(FRAME_BEATS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (start_rise && !run) begin
      beat_cnt <= '0;
    end else if (beat_ok) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // one cycle register stage into the fifo
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_en <= 1'b0;
    end else begin
      o_wr_en <= beat_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_ok) begin
      o_wr_data <= i_rdata;
      o_wr_last <= frame_end;
    end
  end

endmodule

// File: src/axi_rd_ram.sv
module axi_rd_ram #(
  parameter int MEM_WORDS  = 256,
  parameter int RD_LATENCY = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // ar channel
  input  logic                               i_arvalid,
  output logic                               o_arready,
  input  logic [frame_rd_pkg::ADDR_W-1:0]    i_araddr,
  input  logic [frame_rd_pkg::LEN_W-1:0]     i_arlen,
  input  logic [frame_rd_pkg::SIZE_W-1:0]    i_arsize,
  input  logic [frame_rd_pkg::BURST_W-1:0]   i_arburst,
  input  logic [frame_rd_pkg::ID_W-1:0]      i_arid,
  // r channel
  output logic                               o_rvalid,
  input  logic                               i_rready,
  output logic [frame_rd_pkg::DATA_W-1:0]    o_rdata,
  output logic                               o_rlast,
  output logic [frame_rd_pkg::RESP_W-1:0]    o_rresp,
  output logic [frame_rd_pkg::ID_W-1:0]      o_rid,
  // loader port
  input  logic                               i_wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]       i_wr_addr,
  input  logic [frame_rd_pkg::DATA_W-1:0]    i_wr_data
);
  import frame_rd_pkg::*;

  localparam int PTR_W = $clog2(MEM_WORDS);
  localparam int LAT_W = $clog2(RD_LATENCY + 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WAIT  = 2'd1;
  localparam logic [1:0] ST_BURST = 2'd2;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  logic [1:0]       state;
  logic [LAT_W-1:0] lat_cnt;
  logic [LEN_W-1:0] beat_cnt;
  logic [LEN_W-1:0] len_q;
  logic [PTR_W-1:0] ptr;
  logic             incr_q;
  logic             ar_hs;
  logic             last_beat;
  logic             load_beat;

  assign o_arready = (state == ST_IDLE);
  assign ar_hs     = i_arvalid & o_arready;
  assign last_beat = (beat_cnt == len_q);

  // fetch a word on the first beat and on every accepted non-last beat
  assign load_beat = ((state == ST_WAIT) && (lat_cnt == '0)) ||
                     ((state == ST_BURST) && o_rvalid && i_rready && !last_beat);

  //********************
  // burst FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      lat_cnt  <= '0;
      beat_cnt <= '0;
      o_rvalid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ar_hs) begin
            state   <= ST_WAIT;
            lat_cnt <= LAT_W'(RD_LATENCY - 1);
          end
        end
        ST_WAIT: begin
          if (lat_cnt == '0) begin
            state    <= ST_BURST;
            o_rvalid <= 1'b1;
            beat_cnt <= '0;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        ST_BURST: begin
          if (o_rvalid && i_rready) begin
            if (last_beat) begin
              o_rvalid <= 1'b0;
              state    <= ST_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //********************
  // request capture and ram
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      // address in units of the transfer size
      ptr    <= PTR_W'(i_araddr >> i_arsize);
      len_q  <= i_arlen;
      incr_q <= (i_arburst == BURST_INCR);
      o_rid  <= i_arid;
    end else if (load_beat && incr_q) begin
      ptr <= ptr + 1'b1;
    end
    if (load_beat) begin
      o_rdata <= mem[ptr];
    end
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rlast = o_rvalid & last_beat;
  assign o_rresp = RESP_OKAY;

endmodule

// File: src/sample_fifo.sv
module sample_fifo #(
  parameter int DEPTH       = 32,
  parameter int AFULL_LEVEL = 24,
  parameter int WIDTH       = 129
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // write side
  input  logic                       i_wr_en,
  input  logic [WIDTH-1:0]           i_wr_data,
  // read side, show-ahead
  input  logic                       i_rd_en,
  output logic [WIDTH-1:0]           o_rd_data,
  // status
  output logic                       o_empty,
  output logic                       o_afull,
  output logic [$clog2(DEPTH+1)-1:0] o_count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // writes to a full fifo and reads from an empty one are dropped
  assign do_wr = i_wr_en && (count != CNT_W'(DEPTH));
  assign do_rd = i_rd_en && (count != '0);

  //********************
  // pointers and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_rd) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //********************
  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // head word visible without a read request
  assign o_rd_data = mem[rd_ptr];

  assign o_empty = (count == '0);
  assign o_afull = (count >= CNT_W'(AFULL_LEVEL));
  assign o_count = count;

endmodule

// File: src/frame_reader_top.sv
module frame_reader_top #(
  parameter int FRAME_BEATS = frame_rd_pkg::DEF_FRAME_BEATS,
  parameter int BURST_LEN   = frame_rd_pkg::DEF_BURST_LEN,
  parameter int BASE_ADDR   = frame_rd_pkg::DEF_BASE_ADDR,
  parameter int FIFO_DEPTH  = frame_rd_pkg::DEF_FIFO_DEPTH,
  parameter int MEM_WORDS   = frame_rd_pkg::DEF_MEM_WORDS,
  parameter int RD_LATENCY  = frame_rd_pkg::DEF_RD_LATENCY
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            i_start,
  // memory loader
  input  logic                            i_wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0]    i_wr_addr,
  input  logic [frame_rd_pkg::DATA_W-1:0] i_wr_data,
  // sample stream
  output logic [frame_rd_pkg::DATA_W-1:0] o_data,
  output logic                            o_data_valid,
  output logic                            o_data_last,
  input  logic                            i_data_ready
);
  import frame_rd_pkg::*;

  // room for one whole burst above the threshold
  localparam int AFULL_LEVEL = FIFO_DEPTH - BURST_LEN;
  localparam int FIFO_W      = DATA_W + 1;
  localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);

  // axi4 read bus
  logic               arvalid;
  logic               arready;
  logic [ADDR_W-1:0]  araddr;
  logic [LEN_W-1:0]   arlen;
  logic [SIZE_W-1:0]  arsize;
  logic [BURST_W-1:0] arburst;
  logic [ID_W-1:0]    arid;
  logic               rvalid;
  logic               rready;
  logic [DATA_W-1:0]  rdata;
  logic               rlast;
  logic [RESP_W-1:0]  rresp;
  logic [ID_W-1:0]    rid;

  // sample fifo
  logic               fifo_wr_en;
  logic [DATA_W-1:0]  fifo_wr_data;
  logic               fifo_wr_last;
  logic               fifo_afull;
  logic               fifo_empty;
  logic               fifo_rd_en;
  logic [FIFO_W-1:0]  fifo_rd_data;
  logic [CNT_W-1:0]   fifo_count;

  axi_frame_rd_master #(
    .FRAME_BEATS (FRAME_BEATS),
    .BURST_LEN   (BURST_LEN),
    .BASE_ADDR   (BASE_ADDR)
  ) u_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_fifo_afull (fifo_afull),
    .o_arvalid    (arvalid),
    .i_arready    (arready),
    .o_araddr     (araddr),
    .o_arlen      (arlen),
    .o_arsize     (arsize),
    .o_arburst    (arburst),
    .o_arid       (arid),
    .i_rvalid     (rvalid),
    .o_rready     (rready),
    .i_rdata      (rdata),
    .i_rlast      (rlast),
    .i_rresp      (rresp),
    .i_rid        (rid),
    .o_wr_en      (fifo_wr_en),
    .o_wr_data    (fifo_wr_data),
    .o_wr_last    (fifo_wr_last)
  );

  axi_rd_ram #(
    .MEM_WORDS  (MEM_WORDS),
    .RD_LATENCY (RD_LATENCY)
  ) u_ram (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arsize  (arsize),
    .i_arburst (arburst),
    .i_arid    (arid),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rlast   (rlast),
    .o_rresp   (rresp),
    .o_rid     (rid),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data)
  );

  // last flag rides in the top bit
  sample_fifo #(
    .DEPTH       (FIFO_DEPTH),
    .AFULL_LEVEL (AFULL_LEVEL),
    .WIDTH       (FIFO_W)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_wr_en   (fifo_wr_en),
    .i_wr_data ({fifo_wr_last, fifo_wr_data}),
    .i_rd_en   (fifo_rd_en),
    .o_rd_data (fifo_rd_data),
    .o_empty   (fifo_empty),
    .o_afull   (fifo_afull),
    .o_count   (fifo_count)
  );

  assign o_data_valid = ~fifo_empty;
  assign fifo_rd_en   = i_data_ready & o_data_valid;
  assign o_data       = fifo_rd_data[DATA_W-1:0];
  assign o_data_last  = fifo_rd_data[DATA_W];

endmodule

// File: tests/clk_gen.sv
module clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // reset held for RST_CYCLES rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tests/frame_reader_checker.sv
module frame_reader_checker #(
  parameter int FRAME_BEATS = 64,
  parameter int BURST_LEN   = 8,
  parameter int BASE_ADDR   = 0,
  parameter int FIFO_DEPTH  = 32,
  parameter int MEM_WORDS   = 256
) (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              i_wr_en,
  input logic [$clog2(MEM_WORDS)-1:0]      i_wr_addr,
  input logic [frame_rd_pkg::DATA_W-1:0]   i_wr_data,
  input logic [frame_rd_pkg::DATA_W-1:0]   i_data,
  input logic                              i_data_valid,
  input logic                              i_data_last,
  input logic                              i_data_ready,
  input logic                              i_arvalid,
  input logic                              i_arready,
  input logic [frame_rd_pkg::ADDR_W-1:0]   i_araddr,
  input logic [frame_rd_pkg::LEN_W-1:0]    i_arlen,
  input logic [frame_rd_pkg::SIZE_W-1:0]   i_arsize,
  input logic [frame_rd_pkg::BURST_W-1:0]  i_arburst,
  input logic                              i_fifo_wr_en,
  input logic                              i_fifo_afull,
  input logic [$clog2(FIFO_DEPTH+1)-1:0]   i_fifo_count
);
  import frame_rd_pkg::*;

  localparam int BURSTS      = FRAME_BEATS / BURST_LEN;
  localparam int BASE_WORD   = BASE_ADDR / BYTES_PER_WORD;
  localparam int BURST_BYTES = BURST_LEN * BYTES_PER_WORD;

  logic [DATA_W-1:0] shadow [MEM_WORDS];
  logic [DATA_W-1:0] exp_word;
  logic [ADDR_W-1:0] exp_addr;
  logic              pop;
  logic              ar_hs;
  int                exp_idx;
  int                burst_num;
  int                fail_count = 0;

  assign pop      = i_data_valid & i_data_ready;
  assign ar_hs    = i_arvalid & i_arready;
  assign exp_word = shadow[(BASE_WORD + exp_idx) % MEM_WORDS];
  assign exp_addr = ADDR_W'(BASE_ADDR + burst_num * BURST_BYTES);

  //********************
  // shadow state
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      shadow[i_wr_addr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_idx   <= 0;
      burst_num <= 0;
    end else begin
      if (pop) begin
        exp_idx <= (exp_idx == FRAME_BEATS - 1) ? 0 : exp_idx + 1;
      end
      if (ar_hs) begin
        burst_num <= (burst_num == BURSTS - 1) ? 0 : burst_num + 1;
      end
    end
  end

  //********************
  // output stream
  a_data_order: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> i_data == exp_word)
    else begin
      fail_count++;
      $error("FAILED o_data got %h expected %h", $sampled(i_data), $sampled(exp_word));
    end

  a_frame_end: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> i_data_last == (exp_idx == FRAME_BEATS - 1))
    else begin
      fail_count++;
      $error("FAILED o_data_last got %h expected %h", $sampled(i_data_last),
             $sampled(exp_idx == FRAME_BEATS - 1));
    end

  //********************
  // ar channel
  a_arlen: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> i_arlen == LEN_W'(BURST_LEN - 1))
    else begin
      fail_count++;
      $error("FAILED arlen got %h expected %h", $sampled(i_arlen), LEN_W'(BURST_LEN - 1));
    end

  a_arburst: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> i_arburst == BURST_INCR)
    else begin
      fail_count++;
      $error("FAILED arburst got %h expected %h", $sampled(i_arburst), BURST_INCR);
    end

  a_arsize: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> i_arsize == SIZE_CODE)
    else begin
      fail_count++;
      $error("FAILED arsize got %h expected %h", $sampled(i_arsize), SIZE_CODE);
    end

  a_araddr: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> i_araddr == exp_addr)
    else begin
      fail_count++;
      $error("FAILED araddr got %h expected %h", $sampled(i_araddr), $sampled(exp_addr));
    end

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      fail_count++;
      $error("arvalid dropped or araddr changed before arready");
    end

  //********************
  // fifo room, reset and restart
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    i_fifo_wr_en |-> i_fifo_count != FIFO_DEPTH)
    else begin
      fail_count++;
      $error("FAILED fifo_count got %h at a write, limit %h", $sampled(i_fifo_count),
             FIFO_DEPTH);
    end

  a_afull_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_fifo_afull |-> !ar_hs)
    else begin
      fail_count++;
      $error("address request accepted while the fifo was almost full");
    end

  a_reset: assert property (@(posedge clk)
    !rst_n |-> !i_arvalid && !i_data_valid)
    else begin
      fail_count++;
      $error("arvalid or o_data_valid high during reset");
    end

  // a new frame only begins once the previous one has drained
  a_restart: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs && burst_num == 0 |-> exp_idx == 0)
    else begin
      fail_count++;
      $error("FAILED stream index got %h expected 0 at frame start", $sampled(exp_idx));
    end

endmodule

// File: tests/tb_frame_reader.sv
module tb_frame_reader;
  import frame_rd_pkg::*;

  localparam int FRAME_BEATS = DEF_FRAME_BEATS;
  localparam int BURST_LEN   = DEF_BURST_LEN;
  localparam int BASE_ADDR   = DEF_BASE_ADDR;
  localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;
  localparam int MEM_WORDS   = DEF_MEM_WORDS;
  localparam int RD_LATENCY  = DEF_RD_LATENCY;
  localparam int WAIT_LIMIT  = 4000;

  logic                         clk;
  logic                         rst_n;
  logic                         i_start;
  logic                         i_wr_en;
  logic [$clog2(MEM_WORDS)-1:0] i_wr_addr;
  logic [DATA_W-1:0]            i_wr_data;
  logic [DATA_W-1:0]            o_data;
  logic                         o_data_valid;
  logic                         o_data_last;
  logic                         i_data_ready;
  int                           seed;

  clk_gen #(.PERIOD(40), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  frame_reader_top #(
    .FRAME_BEATS (FRAME_BEATS),
    .BURST_LEN   (BURST_LEN),
    .BASE_ADDR   (BASE_ADDR),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MEM_WORDS   (MEM_WORDS),
    .RD_LATENCY  (RD_LATENCY)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_wr_en      (i_wr_en),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .o_data       (o_data),
    .o_data_valid (o_data_valid),
    .o_data_last  (o_data_last),
    .i_data_ready (i_data_ready)
  );

  bind frame_reader_top frame_reader_checker #(
    .FRAME_BEATS (FRAME_BEATS),
    .BURST_LEN   (BURST_LEN),
    .BASE_ADDR   (BASE_ADDR),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MEM_WORDS   (MEM_WORDS)
  ) u_checker (
    .clk (clk), .rst_n (rst_n),
    .i_wr_en (i_wr_en), .i_wr_addr (i_wr_addr), .i_wr_data (i_wr_data),
    .i_data (o_data), .i_data_valid (o_data_valid), .i_data_last (o_data_last),
    .i_data_ready (i_data_ready),
    .i_arvalid (arvalid), .i_arready (arready), .i_araddr (araddr),
    .i_arlen (arlen), .i_arsize (arsize), .i_arburst (arburst),
    .i_fifo_wr_en (fifo_wr_en), .i_fifo_afull (fifo_afull), .i_fifo_count (fifo_count)
  );

  //********************
  // helpers
  task automatic abort_run(input string reason);
    $display("sim failed");
    $fatal(1, "%s", reason);
  endtask

  function automatic logic [DATA_W-1:0] random_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic draw_ready(input int ready_pct);
    return ($unsigned($random(seed)) % 100) < ready_pct;
  endfunction

  task automatic wait_reset_release();
    int cyc;
    for (cyc = 0; cyc < 20 && !rst_n; cyc++) begin
      @(negedge clk);
    end
    if (!rst_n) begin
      abort_run("reset was never released");
    end
  endtask

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      i_wr_en   <= 1'b1;
      i_wr_addr <= i[$clog2(MEM_WORDS)-1:0];
      i_wr_data <= random_word();
    end
    @(posedge clk);
    i_wr_en <= 1'b0;
  endtask

  // run one frame while popping with a random ready of ready_pct percent
  task automatic run_frame(input int ready_pct);
    int  cyc;
    logic seen_last;
    seen_last = 1'b0;
    @(posedge clk);
    i_start <= 1'b1;
    repeat (4) @(posedge clk);
    i_start <= 1'b0;
    for (cyc = 0; cyc < WAIT_LIMIT && !seen_last; cyc++) begin
      @(posedge clk);
      i_data_ready <= draw_ready(ready_pct);
      // a start edge mid-fetch that the master must ignore
      if (cyc == 20) begin
        i_start <= 1'b1;
      end else if (cyc == 24) begin
        i_start <= 1'b0;
      end
      @(negedge clk);
      if (o_data_valid && i_data_ready && o_data_last) begin
        seen_last = 1'b1;
      end
    end
    if (!seen_last) begin
      abort_run("timed out waiting for the last word of the frame");
    end else begin
      // the last word leaves on this edge
      @(posedge clk);
      i_data_ready <= 1'b0;
    end
  endtask

  // stop at the first assertion failure
  always @(posedge clk) begin
    if (DUT.u_checker.fail_count != 0) begin
      abort_run("the checker reported an assertion failure");
    end
  end

  //********************
  // main sequence
  initial begin
    seed = 32'h81fc90a3;
    i_start      <= 1'b0;
    i_wr_en      <= 1'b0;
    i_wr_addr    <= '0;
    i_wr_data    <= '0;
    i_data_ready <= 1'b0;
    wait_reset_release();
    load_memory();
    // slow consumer fills the fifo up to almost full
    run_frame(25);
    run_frame(80);
    repeat (4) @(posedge clk);
    if (DUT.u_checker.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("the checker reported an assertion failure");
    end
  end

endmodule

// File: project.f
src/frame_rd_pkg.sv
src/axi_frame_rd_master.sv
src/axi_rd_ram.sv
src/sample_fifo.sv
src/frame_reader_top.sv
tests/clk_gen.sv
tests/frame_reader_checker.sv
tests/tb_frame_reader.sv
